// ==== build.f ====
turbo_pkg.sv
soft_input_loader.sv
extrinsic_unit.sv
turbo_iter_ctrl.sv
turbo_decoder_top.sv
tb_turbo_assert.sv
tb_turbo_decoder.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the turbo decoder testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_turbo_decoder \
    -f build.f -o sim_turbo || exit 1
./obj_dir/sim_turbo > sim.log 2>&1
cat sim.log
grep -q "Test failures found" sim.log && echo "simulation FAILED" && exit 1
grep -q "All tests passed!" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation ok"
exit 0

// ==== tb_turbo_decoder.sv ====
`default_nettype none
`timescale 1ns/10ps

module tb_turbo_decoder;

    import turbo_pkg::*;

    localparam int MAX_ITER    = 16;
    localparam int NUM_ROWS    = 12;
    localparam int CYCLE_LIMIT = NUM_ROWS * 2 * MAX_ITER * 12 + 400;
    localparam int LLR_HI      = 511;
    localparam int LLR_LO      = -512;
    // interleaved slot j reads natural position IL_ORDER[j]
    localparam int IL_ORDER [INFO_LEN] = '{0, 4, 2, 1, 3};

    typedef struct packed {
        soft_vec_t  sys;
        soft_vec_t  par1;
        soft_vec_t  par2;
        logic       flip;
        logic       restart;
        logic [7:0] gain;
        decision_t  exp_dec;
        logic [7:0] exp_cnt;
    } test_row_t;

    logic      clk_p_i;
    logic      reset_n_i;
    logic      start_i;
    plane_t    data_i;
    logic      siso_done_i;
    llr_vec_t  siso_llr_i;
    logic      siso_start_o;
    siso_req_t siso_req_o;
    logic      done_o;
    decision_t data_o;

    test_row_t   rows [NUM_ROWS];
    test_row_t   cur_row;
    logic [31:0] rng_state  = 32'h240b_6187;
    int          err_cnt    = 0;
    int          check_cnt  = 0;
    int          fail_tests = 0;
    int          req_cnt    = 0;
    int          done_total = 0;
    int          cycle_cnt  = 0;
    int          cur_gain   = 1;
    logic        cur_flip   = 1'b0;
    logic        half2_flag = 1'b0;
    decision_t   done_data;

    turbo_decoder_top #(
        .MAX_ITER (MAX_ITER)
    ) uut (
        .clk_p_i      (clk_p_i),
        .reset_n_i    (reset_n_i),
        .start_i      (start_i),
        .data_i       (data_i),
        .siso_done_i  (siso_done_i),
        .siso_llr_i   (siso_llr_i),
        .siso_start_o (siso_start_o),
        .siso_req_o   (siso_req_o),
        .done_o       (done_o),
        .data_o       (data_o)
    );

    initial begin : clock_gen
        clk_p_i = 1'b0;
        forever begin
            #10 clk_p_i = ~clk_p_i;
        end
    end

    always @(posedge clk_p_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: no final result after %0d cycles", cycle_cnt);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int clamp_llr(int x);
        if (x > LLR_HI) begin
            return LLR_HI;
        end
        if (x < LLR_LO) begin
            return LLR_LO;
        end
        return x;
    endfunction

    function automatic int soft_at(soft_vec_t v, int pos);
        logic signed [SOFT_W-1:0] s;
        s = v[(BLOCK_LEN-1-pos)*SOFT_W +: SOFT_W];
        return int'(s);
    endfunction

    function automatic int llr_at(llr_vec_t v, int pos);
        logic signed [LLR_W-1:0] l;
        l = v[(BLOCK_LEN-1-pos)*LLR_W +: LLR_W];
        return int'(l);
    endfunction

    function automatic soft_vec_t fill_vec(int val);
        soft_vec_t v;
        for (int p = 0; p < BLOCK_LEN; p++) begin
            v[(BLOCK_LEN-1-p)*SOFT_W +: SOFT_W] = val[SOFT_W-1:0];
        end
        return v;
    endfunction

    // interleaved slot j takes natural position IL_ORDER[j], pads zero
    function automatic soft_vec_t interleave_sys(soft_vec_t v);
        soft_vec_t r;
        r = '0;
        for (int j = 0; j < INFO_LEN; j++) begin
            r[(BLOCK_LEN-1-j)*SOFT_W +: SOFT_W] =
                v[(BLOCK_LEN-1-IL_ORDER[j])*SOFT_W +: SOFT_W];
        end
        return r;
    endfunction

    // every position either +7 or -8
    function automatic soft_vec_t extreme_vec();
        logic [31:0] r;
        soft_vec_t   v;
        r = next_rand();
        for (int p = 0; p < BLOCK_LEN; p++) begin
            v[(BLOCK_LEN-1-p)*SOFT_W +: SOFT_W] = r[p] ? 4'h7 : 4'h8;
        end
        return v;
    endfunction

    function automatic plane_t make_plane(soft_vec_t s, soft_vec_t a, soft_vec_t b, int k);
        plane_t pl;
        for (int p = 0; p < BLOCK_LEN; p++) begin
            pl[3*BLOCK_LEN-1-p] = s[(BLOCK_LEN-1-p)*SOFT_W + k];
            pl[2*BLOCK_LEN-1-p] = a[(BLOCK_LEN-1-p)*SOFT_W + k];
            pl[BLOCK_LEN-1-p]   = b[(BLOCK_LEN-1-p)*SOFT_W + k];
        end
        return pl;
    endfunction

    // SISO rule: apriori + gain*(2*sys + 3*par), clamped, optionally negated
    function automatic llr_vec_t siso_answer(siso_req_t req, logic negate, int gain);
        llr_vec_t res;
        int       v;
        for (int p = 0; p < BLOCK_LEN; p++) begin
            v = clamp_llr(llr_at(req.apriori, p)
                          + gain * (2 * soft_at(req.sys, p) + 3 * soft_at(req.par, p)));
            if (negate) begin
                v = clamp_llr(-v);
            end
            res[(BLOCK_LEN-1-p)*LLR_W +: LLR_W] = v[LLR_W-1:0];
        end
        return res;
    endfunction

    function automatic test_row_t make_row(soft_vec_t s, soft_vec_t a, soft_vec_t b,
                                           logic flip, logic restart, int gain,
                                           decision_t exp_dec, int exp_cnt);
        test_row_t r;
        r.sys     = s;
        r.par1    = a;
        r.par2    = b;
        r.flip    = flip;
        r.restart = restart;
        r.gain    = gain[7:0];
        r.exp_dec = exp_dec;
        r.exp_cnt = exp_cnt[7:0];
        return r;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error: %s = %0h, expected %0h at %0t", name, got, exp, $time);
        end
    endtask

    // half 1 carries natural sys and parity one, half 2 interleaved sys and parity two
    task automatic check_request(input siso_req_t req, input logic half2);
        if (half2) begin
            compare("siso_req_o.sys", 32'(req.sys), 32'(interleave_sys(cur_row.sys)));
            compare("siso_req_o.par", 32'(req.par), 32'(cur_row.par2));
        end else begin
            compare("siso_req_o.sys", 32'(req.sys), 32'(cur_row.sys));
            compare("siso_req_o.par", 32'(req.par), 32'(cur_row.par1));
        end
    endtask

    // plain integer version of the iteration rules
    task automatic model_decode(input test_row_t r, output decision_t dec, output int cnt);
        int   s      [INFO_LEN];
        int   s_il   [INFO_LEN];
        int   p1     [INFO_LEN];
        int   p2     [INFO_LEN];
        int   a_nat  [INFO_LEN];
        int   e1_il  [INFO_LEN];
        int   e1_nat [INFO_LEN];
        int   e2_nat [INFO_LEN];
        int   l;
        int   g;
        int   p;
        logic agree;
        g = int'(r.gain);
        for (int i = 0; i < INFO_LEN; i++) begin
            s[i]     = soft_at(r.sys, i);
            p1[i]    = soft_at(r.par1, i);
            p2[i]    = soft_at(r.par2, i);
            a_nat[i] = 0;
        end
        for (int j = 0; j < INFO_LEN; j++) begin
            s_il[j] = s[IL_ORDER[j]];
        end
        dec = '0;
        cnt = 0;
        for (int it = 1; it <= MAX_ITER; it++) begin
            for (int j = 0; j < INFO_LEN; j++) begin
                p = IL_ORDER[j];
                l = clamp_llr(a_nat[p] + g * (2 * s[p] + 3 * p1[p]));
                e1_il[j]  = clamp_llr(clamp_llr(clamp_llr(l - a_nat[p]) - s[p]) - s[p]);
                e1_nat[p] = e1_il[j];
            end
            for (int j = 0; j < INFO_LEN; j++) begin
                l = clamp_llr(e1_il[j] + g * (2 * s_il[j] + 3 * p2[j]));
                if (r.flip) begin
                    l = clamp_llr(-l);
                end
                e2_nat[IL_ORDER[j]] =
                    clamp_llr(clamp_llr(clamp_llr(l - e1_il[j]) - s_il[j]) - s_il[j]);
            end
            cnt   = cnt + 2;
            agree = 1'b1;
            for (int i = 0; i < INFO_LEN; i++) begin
                dec[INFO_LEN-1-i] = (e2_nat[i] >= 0);
                if ((e1_nat[i] >= 0) != (e2_nat[i] >= 0)) begin
                    agree = 1'b0;
                end
                a_nat[i] = e2_nat[i];
            end
            if (agree || it == MAX_ITER) begin
                break;
            end
        end
    endtask

    task automatic build_table();
        decision_t dec;
        int        cnt;
        rows[0] = make_row(fill_vec(7), fill_vec(7), fill_vec(7), 0, 0, 1, 5'b11111, 2);
        rows[1] = make_row(fill_vec(-8), fill_vec(-8), fill_vec(-8), 0, 0, 1, 5'b00000, 2);
        for (int i = 2; i < 8; i++) begin
            rows[i] = make_row(soft_vec_t'(next_rand()), soft_vec_t'(next_rand()),
                               soft_vec_t'(next_rand()), 0, 0, 1, '0, 0);
        end
        // half-2 answers negated, decisions keep disagreeing
        rows[8]  = make_row(fill_vec(7), fill_vec(7), fill_vec(7), 1, 0, 1,
                            5'b00000, 2 * MAX_ITER);
        rows[9]  = make_row(extreme_vec(), fill_vec(-8), fill_vec(7), 0, 0, 24, '0, 0);
        rows[10] = make_row(extreme_vec(), extreme_vec(), extreme_vec(), 1, 0, 31, '0, 0);
        rows[11] = make_row(fill_vec(5), fill_vec(3), fill_vec(6), 1, 1, 1, '0, 0);
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (rows[i].exp_cnt == 0) begin
                model_decode(rows[i], dec, cnt);
                rows[i].exp_dec = dec;
                rows[i].exp_cnt = cnt[7:0];
            end
        end
    endtask

    // four planes on consecutive cycles, start with plane 0
    task automatic load_block(input soft_vec_t s, input soft_vec_t a, input soft_vec_t b);
        for (int k = 0; k < PLANES; k++) begin
            start_i = (k == 0);
            data_i  = make_plane(s, a, b, k);
            @(negedge clk_p_i);
        end
        start_i = 1'b0;
        data_i  = '0;
    endtask

    initial begin : siso_model
        siso_req_t req;
        int        lat;
        forever begin
            @(negedge clk_p_i);
            siso_done_i = 1'b0;
            if (reset_n_i && siso_start_o) begin
                req = siso_req_o;
                req_cnt++;
                check_request(req, half2_flag);
                lat = 2 + int'(next_rand() % 8);
                repeat (lat - 1) @(negedge clk_p_i);
                siso_llr_i  = siso_answer(req, half2_flag && cur_flip, cur_gain);
                siso_done_i = 1'b1;
                half2_flag  = !half2_flag;
            end
        end
    end

    // result capture, data_o must stay zero until the first decision
    always @(negedge clk_p_i) begin
        if (reset_n_i) begin
            if (done_o) begin
                done_total = done_total + 1;
                done_data  = data_o;
            end else if (done_total == 0) begin
                compare("data_o", 32'(data_o), 32'h0);
            end
        end
    end

    task automatic run_row(input int idx);
        test_row_t r;
        int        errs_before;
        int        done_before;
        r           = rows[idx];
        errs_before = err_cnt;
        done_before = done_total;
        cur_row     = r;
        cur_flip    = r.flip;
        cur_gain    = int'(r.gain);
        req_cnt     = 0;
        half2_flag  = 1'b0;
        load_block(r.sys, r.par1, r.par2);
        if (r.restart) begin
            while (req_cnt < 1) begin
                @(negedge clk_p_i);
            end
            load_block(~r.sys, ~r.par1, ~r.par2);
        end
        while (done_total == done_before) begin
            @(negedge clk_p_i);
        end
        compare("data_o", 32'(done_data), 32'(r.exp_dec));
        compare("siso_start_o count", 32'(req_cnt), 32'(r.exp_cnt));
        repeat (6) @(negedge clk_p_i);
        compare("done_o pulses", 32'(done_total - done_before), 32'd1);
        compare("data_o held", 32'(data_o), 32'(r.exp_dec));
        if (err_cnt != errs_before) begin
            fail_tests++;
        end
        $display("test %0d: %s, decision %b after %0d requests", idx,
                 (err_cnt == errs_before) ? "ok" : "FAILED", done_data, req_cnt);
    endtask

    initial begin : main
        reset_n_i   = 1'b0;
        start_i     = 1'b0;
        data_i      = '0;
        siso_done_i = 1'b0;
        siso_llr_i  = '0;
        build_table();
        repeat (16) @(negedge clk_p_i);
        reset_n_i = 1'b1;
        repeat (4) @(negedge clk_p_i);
        compare("done_o", 32'(done_o), 32'h0);
        compare("siso_start_o", 32'(siso_start_o), 32'h0);
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 NUM_ROWS, fail_tests, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_turbo_assert.sv ====
`default_nettype none
`timescale 1ns/10ps

module tb_turbo_assert (
    input wire                       clk_p_i,
    input wire                       reset_n_i,
    input wire                       block_ready_i,
    input wire                       siso_start_i,
    input wire                       siso_done_i,
    input wire turbo_pkg::siso_req_t siso_req_i,
    input wire                       done_i
);

    logic req_open;
    logic block_seen;

    // a request is open from its start pulse until the done pulse
    always_ff @(posedge clk_p_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            req_open <= 1'b0;
        end else if (siso_start_i) begin
            req_open <= 1'b1;
        end else if (siso_done_i) begin
            req_open <= 1'b0;
        end
    end

    // set by the first block after reset
    always_ff @(posedge clk_p_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            block_seen <= 1'b0;
        end else if (block_ready_i) begin
            block_seen <= 1'b1;
        end
    end

    single_request: assert property (
        @(posedge clk_p_i) disable iff (!reset_n_i)
        siso_start_i |-> !req_open
    ) else $error("siso_start_o asserted while a request is outstanding");

    request_stable: assert property (
        @(posedge clk_p_i) disable iff (!reset_n_i)
        ((siso_start_i || req_open) && !siso_done_i) |=> $stable(siso_req_i)
    ) else $error("siso_req_o changed before siso_done_i");

    done_one_cycle: assert property (
        @(posedge clk_p_i) disable iff (!reset_n_i)
        done_i |=> !done_i
    ) else $error("done_o high for more than one cycle");

    // outputs quiet after reset until the first block arrives
    quiet_after_reset: assert property (
        @(posedge clk_p_i) disable iff (!reset_n_i)
        !block_seen |-> (!done_i && !siso_start_i)
    ) else $error("done_o or siso_start_o high before the first block");

endmodule

bind turbo_iter_ctrl tb_turbo_assert u_handshake_assert (
    .clk_p_i       (clk_p_i),
    .reset_n_i     (reset_n_i),
    .block_ready_i (block_ready_i),
    .siso_start_i  (siso_start_o),
    .siso_done_i   (siso_done_i),
    .siso_req_i    (siso_req_o),
    .done_i        (done_o)
);

`default_nettype wire

// ==== turbo_decoder_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module turbo_decoder_top #(
    parameter int MAX_ITER = 16
) (
    input  wire                    clk_p_i,
    input  wire                    reset_n_i,
    input  wire                    start_i,
    input  wire turbo_pkg::plane_t    data_i,
    input  wire                    siso_done_i,
    input  wire turbo_pkg::llr_vec_t  siso_llr_i,
    output wire                    siso_start_o,
    output turbo_pkg::siso_req_t   siso_req_o,
    output wire                    done_o,
    output turbo_pkg::decision_t   data_o
);

    import turbo_pkg::*;

    logic      block_ready;
    soft_vec_t sys_vec;
    soft_vec_t par1_vec;
    soft_vec_t par2_vec;
    llr_vec_t  ext_a;
    llr_vec_t  ext_b;
    llr_vec_t  apriori;
    soft_vec_t half_sys;

    soft_input_loader u_loader (
        .clk_p_i       (clk_p_i),
        .reset_n_i     (reset_n_i),
        .start_i       (start_i),
        .data_i        (data_i),
        .block_ready_o (block_ready),
        .sys_o         (sys_vec),
        .par1_o        (par1_vec),
        .par2_o        (par2_vec)
    );

    // half 1, natural in
    extrinsic_unit #(
        .INTERLEAVED_IN (1'b0)
    ) ext_unit_a (
        .siso_llr_i (siso_llr_i),
        .apriori_i  (apriori),
        .sys_i      (half_sys),
        .ext_o      (ext_a)
    );

    // half 2, interleaved in
    extrinsic_unit #(
        .INTERLEAVED_IN (1'b1)
    ) ext_unit_b (
        .siso_llr_i (siso_llr_i),
        .apriori_i  (apriori),
        .sys_i      (half_sys),
        .ext_o      (ext_b)
    );

    turbo_iter_ctrl #(
        .MAX_ITER (MAX_ITER)
    ) u_ctrl (
        .clk_p_i       (clk_p_i),
        .reset_n_i     (reset_n_i),
        .block_ready_i (block_ready),
        .sys_i         (sys_vec),
        .par1_i        (par1_vec),
        .par2_i        (par2_vec),
        .ext_a_i       (ext_a),
        .ext_b_i       (ext_b),
        .siso_done_i   (siso_done_i),
        .siso_start_o  (siso_start_o),
        .siso_req_o    (siso_req_o),
        .apriori_o     (apriori),
        .half_sys_o    (half_sys),
        .done_o        (done_o),
        .data_o        (data_o)
    );

endmodule

`default_nettype wire

// ==== turbo_iter_ctrl.sv ====
`default_nettype none
`timescale 1ns/10ps

module turbo_iter_ctrl #(
    parameter int MAX_ITER = 16
) (
    input  wire                    clk_p_i,
    input  wire                    reset_n_i,
    input  wire                    block_ready_i,
    input  wire turbo_pkg::soft_vec_t sys_i,
    input  wire turbo_pkg::soft_vec_t par1_i,
    input  wire turbo_pkg::soft_vec_t par2_i,
    input  wire turbo_pkg::llr_vec_t  ext_a_i,
    input  wire turbo_pkg::llr_vec_t  ext_b_i,
    input  wire                    siso_done_i,
    output logic                   siso_start_o,
    output turbo_pkg::siso_req_t   siso_req_o,
    output turbo_pkg::llr_vec_t    apriori_o,
    output turbo_pkg::soft_vec_t   half_sys_o,
    output logic                   done_o,
    output turbo_pkg::decision_t   data_o
);

    import turbo_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DEC1,
        ST_DEC2,
        ST_FINISH
    } state_t;

    state_t    state;
    iter_cnt_t iter_cnt;

    // captured block, stays put while a new load runs in the loader
    soft_vec_t sys_q;
    soft_vec_t par1_q;
    soft_vec_t par2_q;

    // half-2 extrinsic (natural) and half-1 extrinsic (interleaved)
    llr_vec_t  apri_nat;
    llr_vec_t  apri_int;

    soft_vec_t sys_int;
    llr_vec_t  half1_nat;
    decision_t dec1;
    decision_t dec2;
    logic      stop;

    // systematic values in interleaved order, pads zero
    always_comb begin
        sys_int = '0;
        for (int j = 0; j < INFO_LEN; j++) begin
            sys_int[(BLOCK_LEN-1-j)*SOFT_W +: SOFT_W] = soft_get(sys_q, PERM[j]);
        end
    end

    // half-1 extrinsic back to natural order for comparison
    always_comb begin
        half1_nat = '0;
        for (int p = 0; p < INFO_LEN; p++) begin
            half1_nat[(BLOCK_LEN-1-p)*LLR_W +: LLR_W] = llr_get(apri_int, PERM_INV[p]);
        end
    end

    assign dec1 = hard_decision(half1_nat);
    assign dec2 = hard_decision(ext_b_i);
    assign stop = (dec1 == dec2) || (iter_cnt == iter_cnt_t'(MAX_ITER-1));

    always_ff @(posedge clk_p_i) begin
        if (state == ST_IDLE && block_ready_i) begin
            sys_q  <= sys_i;
            par1_q <= par1_i;
            par2_q <= par2_i;
        end
    end

    always_ff @(posedge clk_p_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            state        <= ST_IDLE;
            iter_cnt     <= '0;
            siso_start_o <= 1'b0;
            siso_req_o   <= '0;
            apri_nat     <= '0;
            apri_int     <= '0;
            done_o       <= 1'b0;
            data_o       <= '0;
        end else begin
            siso_start_o <= 1'b0;
            done_o       <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // first iteration starts with zero a-priori
                    if (block_ready_i) begin
                        siso_req_o   <= '{sys: sys_i, par: par1_i, apriori: '0};
                        siso_start_o <= 1'b1;
                        state        <= ST_DEC1;
                    end
                end
                ST_DEC1: begin
                    if (siso_done_i) begin
                        apri_int     <= ext_a_i;
                        siso_req_o   <= '{sys: sys_int, par: par2_q, apriori: ext_a_i};
                        siso_start_o <= 1'b1;
                        state        <= ST_DEC2;
                    end
                end
                ST_DEC2: begin
                    if (siso_done_i) begin
                        apri_nat <= ext_b_i;
                        if (stop) begin
                            state <= ST_FINISH;
                        end else begin
                            iter_cnt     <= iter_cnt + 1'b1;
                            siso_req_o   <= '{sys: sys_q, par: par1_q, apriori: ext_b_i};
                            siso_start_o <= 1'b1;
                            state        <= ST_DEC1;
                        end
                    end
                end
                ST_FINISH: begin
                    // decision comes from the last half-2 extrinsic
                    data_o   <= hard_decision(apri_nat);
                    done_o   <= 1'b1;
                    apri_nat <= '0;
                    apri_int <= '0;
                    iter_cnt <= '0;
                    state    <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // extrinsic units see the outstanding request
    assign apriori_o  = siso_req_o.apriori;
    assign half_sys_o = siso_req_o.sys;

endmodule

`default_nettype wire

// ==== extrinsic_unit.sv ====
`default_nettype none
`timescale 1ns/10ps

module extrinsic_unit #(
    parameter bit INTERLEAVED_IN = 1'b0
) (
    input  wire turbo_pkg::llr_vec_t  siso_llr_i,
    input  wire turbo_pkg::llr_vec_t  apriori_i,
    input  wire turbo_pkg::soft_vec_t sys_i,
    output wire turbo_pkg::llr_vec_t  ext_o
);

    import turbo_pkg::*;

    // one slot per information bit
    // natural in -> interleaved out, or interleaved in -> natural out
    for (genvar j = 0; j < INFO_LEN; j++) begin : g_slot
        localparam int IN_IDX  = INTERLEAVED_IN ? j : PERM[j];
        localparam int OUT_IDX = INTERLEAVED_IN ? PERM[j] : j;

        llr_t sys_llr;
        llr_t minus_apri;
        llr_t minus_sys;

        assign sys_llr    = soft_to_llr(soft_get(sys_i, IN_IDX));
        assign minus_apri = sat_sub(llr_get(siso_llr_i, IN_IDX),
                                    llr_get(apriori_i, IN_IDX));
        // systematic term removed twice, matching the 2*sys weight
        assign minus_sys  = sat_sub(minus_apri, sys_llr);

        assign ext_o[(BLOCK_LEN-1-OUT_IDX)*LLR_W +: LLR_W] = sat_sub(minus_sys, sys_llr);
    end

    // pad slots carry no information
    assign ext_o[(BLOCK_LEN-INFO_LEN)*LLR_W-1:0] = '0;

endmodule

`default_nettype wire

// ==== soft_input_loader.sv ====
`default_nettype none
`timescale 1ns/10ps

module soft_input_loader (
    input  wire                  clk_p_i,
    input  wire                  reset_n_i,
    input  wire                  start_i,
    input  wire turbo_pkg::plane_t data_i,
    output logic                 block_ready_o,
    output turbo_pkg::soft_vec_t sys_o,
    output turbo_pkg::soft_vec_t par1_o,
    output turbo_pkg::soft_vec_t par2_o
);

    import turbo_pkg::*;

    plane_t     plane_q;
    logic       loading;
    plane_idx_t plane_idx;

    // load sequencing
    // plane k sits in plane_q while plane_idx == k
    always_ff @(posedge clk_p_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            loading       <= 1'b0;
            plane_idx     <= '0;
            block_ready_o <= 1'b0;
        end else begin
            block_ready_o <= 1'b0;
            if (loading) begin
                plane_idx <= plane_idx + 1'b1;
                if (plane_idx == plane_idx_t'(PLANES-1)) begin
                    loading       <= 1'b0;
                    block_ready_o <= 1'b1;
                end
            end else if (start_i) begin
                loading   <= 1'b1;
                plane_idx <= '0;
            end
        end
    end

    // input register and bit-plane assembly
    always_ff @(posedge clk_p_i) begin
        plane_q <= data_i;
        if (loading) begin
            for (int p = 0; p < BLOCK_LEN; p++) begin
                sys_o[(BLOCK_LEN-1-p)*SOFT_W + int'(plane_idx)] <=
                    plane_q[3*BLOCK_LEN-1-p];
                par1_o[(BLOCK_LEN-1-p)*SOFT_W + int'(plane_idx)] <=
                    plane_q[2*BLOCK_LEN-1-p];
                par2_o[(BLOCK_LEN-1-p)*SOFT_W + int'(plane_idx)] <=
                    plane_q[BLOCK_LEN-1-p];
            end
        end
    end

endmodule

`default_nettype wire

// ==== turbo_pkg.sv ====
`default_nettype none

package turbo_pkg;

    // block geometry
    localparam int SOFT_W    = 4;
    localparam int LLR_W     = 10;
    localparam int INFO_LEN  = 5;
    localparam int BLOCK_LEN = 7;
    localparam int PLANES    = SOFT_W;
    localparam int ITER_W    = 5;

    typedef logic signed [SOFT_W-1:0]          soft_t;
    typedef logic        [BLOCK_LEN*SOFT_W-1:0] soft_vec_t;
    typedef logic signed [LLR_W-1:0]           llr_t;
    typedef logic        [BLOCK_LEN*LLR_W-1:0]  llr_vec_t;
    // sys | parity one | parity two, position 0 on top of each slice
    typedef logic        [3*BLOCK_LEN-1:0]      plane_t;
    typedef logic        [INFO_LEN-1:0]         decision_t;
    typedef logic        [ITER_W-1:0]           iter_cnt_t;
    typedef logic        [$clog2(PLANES)-1:0]   plane_idx_t;

    typedef struct packed {
        soft_vec_t sys;
        soft_vec_t par;
        llr_vec_t  apriori;
    } siso_req_t;

    // interleaved slot j reads natural position PERM[j]
    localparam int PERM     [INFO_LEN] = '{0, 4, 2, 1, 3};
    localparam int PERM_INV [INFO_LEN] = '{0, 3, 2, 4, 1};

    localparam llr_t LLR_MAX = {1'b0, {(LLR_W-1){1'b1}}};
    localparam llr_t LLR_MIN = {1'b1, {(LLR_W-1){1'b0}}};

    // a - b, clamped to the llr range
    function automatic llr_t sat_sub(llr_t a, llr_t b);
        logic [LLR_W:0] diff;
        diff = {a[LLR_W-1], a} - {b[LLR_W-1], b};
        if (diff[LLR_W] != diff[LLR_W-1]) begin
            return diff[LLR_W] ? LLR_MIN : LLR_MAX;
        end
        return llr_t'(diff[LLR_W-1:0]);
    endfunction

    function automatic soft_t soft_get(soft_vec_t v, int pos);
        return v[(BLOCK_LEN-1-pos)*SOFT_W +: SOFT_W];
    endfunction

    function automatic llr_t llr_get(llr_vec_t v, int pos);
        return v[(BLOCK_LEN-1-pos)*LLR_W +: LLR_W];
    endfunction

    // widen a soft value to llr width
    function automatic llr_t soft_to_llr(soft_t s);
        return {{(LLR_W-SOFT_W){s[SOFT_W-1]}}, s};
    endfunction

    // 1 where the value is not negative, info bit 0 on top
    function automatic decision_t hard_decision(llr_vec_t v);
        decision_t d;
        llr_t      l;
        for (int p = 0; p < INFO_LEN; p++) begin
            l = llr_get(v, p);
            d[INFO_LEN-1-p] = ~l[LLR_W-1];
        end
        return d;
    endfunction

endpackage

`default_nettype wire
